// File: project.f
lspcRegPkg.sv
lspcVideoPkg.sv
videoSync.sv
autoAnimTimer.sv
vramAccess.sv
lspcRegs.sv
lspcTop.sv
lspcChecker.sv
lspcTb.sv

// File: Makefile
# Verilator build and simulation of the video controller testbench

VERILATOR ?= verilator
TOP ?= lspcTb
RTL_TOP ?= lspcTop
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
MODE_PAL ?= 0
BUILD_FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GvideoModePal=$(MODE_PAL) -Mdir $(BUILD_DIR) -o $(TOP)

# Verdict comes from the log, not the simulator exit code
run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: lspcTb.sv
// Testbench top for the video controller
// Clock, reset, random CPU requests and bursts, DUT and checker instances
// Closing error counts and verdict

`default_nettype none

module lspcTb #(
	parameter logic videoModePal = 1'b0
);

	import lspcRegPkg::*;
	import lspcVideoPkg::*;

	localparam int reqTimeout = 32;
	localparam int randomRequests = 400;
	localparam int idleFrames = 3;

	logic clk24M;
	logic reset;
	logic cpuReqValid;
	logic cpuReqReady;
	logic cpuWrite;
	regAddrT cpuAddr;
	cpuWordT cpuWrData;
	logic cpuRdValid;
	cpuWordT cpuRdData;
	logic hSync;
	logic vBlank;
	logic [2:0] aaCount;
	int valueErrors;
	int otherErrors;
	logic [7:0] aaSpeed;

	lspcTop #(
		.videoModePal(videoModePal)
	) lspcTop_inst (
		.clk24M(clk24M),
		.reset(reset),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuRdValid(cpuRdValid),
		.cpuRdData(cpuRdData),
		.hSync(hSync),
		.vBlank(vBlank),
		.aaCount(aaCount)
	);

	lspcChecker #(
		.videoModePal(videoModePal)
	) lspcChecker_inst (
		.clk24M(clk24M),
		.reset(reset),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuRdValid(cpuRdValid),
		.cpuRdData(cpuRdData),
		.hSync(hSync),
		.vBlank(vBlank),
		.aaCount(aaCount),
		.valueErrors(valueErrors),
		.otherErrors(otherErrors)
	);

	always #2 clk24M = ~clk24M;

	task automatic reportCounts();
		$display("Value errors: %0d, other failures: %0d", valueErrors, otherErrors);
	endtask

	task automatic failTimeout(input string what);
		$display("Timeout: %s", what);
		reportCounts();
		$display("TEST FAILED");
		$finish;
	endtask

	// Low zone words or a mirror of the high zone
	function automatic cpuWordT pickAddr(input logic [31:0] r);
		return r[31] ? {1'b1, r[14:11], 5'b00000, r[5:0]} : {10'b0, r[5:0]};
	endfunction

	// Request held until ready is seen mid-cycle
	task automatic sendRequest(input logic write, input regAddrT addr, input cpuWordT data);
		int waited;
		logic accepted;
		waited = 0;
		accepted = 1'b0;
		cpuReqValid = 1'b1;
		cpuWrite = write;
		cpuAddr = addr;
		cpuWrData = data;
		while (!accepted) begin
			@(negedge clk24M);
			accepted = cpuReqReady;
			@(posedge clk24M);
			#1;
			waited++;
			if (!accepted && waited > reqTimeout) begin
				failTimeout("CPU request was never accepted");
			end
		end
		cpuReqValid = 1'b0;
	endtask

	// Back-to-back data writes, then read each word back
	task automatic writeBurst(input int count);
		logic [31:0] r;
		cpuWordT base;
		cpuWordT step;
		r = $urandom;
		base = pickAddr(r);
		step = {{11{r[20]}}, r[20:16]};
		sendRequest(1'b1, regVramMod, step);
		sendRequest(1'b1, regVramAddr, base);
		repeat (count) begin
			sendRequest(1'b1, regVramRw, 16'($urandom));
		end
		for (int i = 0; i < count; i++) begin
			sendRequest(1'b1, regVramAddr, base + 16'(i) * step);
			sendRequest(1'b0, regVramRw, 16'h0000);
		end
	endtask

	// Roughly 70 percent writes
	task automatic randomRequest();
		logic [31:0] r;
		r = $urandom;
		if (r[3:0] < 4'd11) begin
			case (r[5:4])
				regVramAddr: sendRequest(1'b1, regVramAddr, pickAddr($urandom));
				regVramRw: sendRequest(1'b1, regVramRw, r[31:16]);
				regVramMod: sendRequest(1'b1, regVramMod, {{11{r[10]}}, r[10:6]});
				// Same speed, junk in the ignored byte
				default: sendRequest(1'b1, regLspcMode, {aaSpeed, r[23:16]});
			endcase
		end else begin
			sendRequest(1'b0, r[5:4], 16'h0000);
		end
	endtask

	// Frames counted on vBlank rising edges
	task automatic waitFrames(input int frames);
		int seen;
		int waited;
		logic prevBlank;
		seen = 0;
		waited = 0;
		prevBlank = vBlank;
		while (seen < frames) begin
			@(negedge clk24M);
			if (vBlank && !prevBlank) begin
				seen++;
			end
			prevBlank = vBlank;
			waited++;
			if (waited > (frames + 1) * 512 * pixelsPerLine * clocksPerPixel) begin
				failTimeout("video frames stopped advancing");
			end
		end
	endtask

	initial begin
		void'($urandom(32'hbb68));
		clk24M = 1'b0;
		reset = 1'b1;
		cpuReqValid = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = regVramAddr;
		cpuWrData = '0;
		aaSpeed = 8'($urandom_range(2, 0));
		repeat (16) begin
			@(posedge clk24M);
		end
		#1;
		reset = 1'b0;
		sendRequest(1'b1, regLspcMode, {aaSpeed, 8'($urandom)});
		for (int i = 0; i < randomRequests; i++) begin
			if (i % 80 == 0) begin
				writeBurst(8);
			end
			randomRequest();
		end
		waitFrames(idleFrames);
		reportCounts();
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: lspcChecker.sv
// Reference model of the video controller
// VRAM with high zone mirroring, address, modulo and read latch
// Raster and auto-animation state derived from hSync edges
// Handshake timing, read data and video timing comparisons

`default_nettype none

module lspcChecker #(
	parameter logic videoModePal = 1'b0
) (
	input wire clk24M,
	input wire reset,
	input wire cpuReqValid,
	input wire cpuReqReady,
	input wire cpuWrite,
	input wire lspcRegPkg::regAddrT cpuAddr,
	input wire lspcRegPkg::cpuWordT cpuWrData,
	input wire cpuRdValid,
	input wire lspcRegPkg::cpuWordT cpuRdData,
	input wire hSync,
	input wire vBlank,
	input wire [2:0] aaCount,
	output int valueErrors,
	output int otherErrors
);

	import lspcRegPkg::*;
	import lspcVideoPkg::*;

	localparam logic [8:0] rasterFirst =
		videoModePal ? 9'(rasterFirstPal) : 9'(rasterFirstNtsc);
	localparam int linePeriod = pixelsPerLine * clocksPerPixel;
	localparam int hSyncHigh = hSyncPixels * clocksPerPixel;

	// Model VRAM, known flags mark words written so far
	cpuWordT lowMem [vramLowWords];
	cpuWordT highMem [vramHighWords];
	logic lowKnown [vramLowWords];
	logic highKnown [vramHighWords];
	cpuWordT addr;
	cpuWordT modulo;
	cpuWordT latch;
	logic latchKnown;

	// Line and frame state
	logic [8:0] raster;
	logic [8:0] curRaster;
	int lineCycle;
	logic prevHSync;
	logic edgeSeen;
	logic [7:0] aaSpeed;
	logic [7:0] aaDiv;
	logic [2:0] aaModel;

	// Handshake state
	int busyLeft;
	logic rdDue;
	logic rdCheck;
	cpuWordT rdExpect;

	function automatic logic [8:0] nextLine(input logic [8:0] line);
		return (line == 9'(rasterLast)) ? rasterFirst : line + 9'd1;
	endfunction

	// High zone decodes 11 bits, low zone 15
	function automatic cpuWordT memRead(input cpuWordT a);
		return a[vramHighBit] ? highMem[a[10:0]] : lowMem[a[14:0]];
	endfunction

	function automatic logic memKnown(input cpuWordT a);
		return a[vramHighBit] ? highKnown[a[10:0]] : lowKnown[a[14:0]];
	endfunction

	task automatic flagMismatch(input string name, input cpuWordT expVal, input cpuWordT gotVal);
		valueErrors++;
		$display("[ERROR] %s expected %h got %h at %0t", name, expVal, gotVal, $time);
	endtask

	task automatic flagFailure(input string what);
		otherErrors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	initial begin
		valueErrors = 0;
		otherErrors = 0;
		for (int i = 0; i < vramLowWords; i++) begin
			lowKnown[i] = 1'b0;
		end
		for (int i = 0; i < vramHighWords; i++) begin
			highKnown[i] = 1'b0;
		end
	end

	// Mid-cycle sampling, inputs and registers are settled here
	always @(negedge clk24M) begin
		if (reset) begin
			addr = '0;
			modulo = '0;
			latch = '0;
			latchKnown = 1'b1;
			raster = rasterFirst;
			// First line change lands on cycle 1536 after reset
			lineCycle = -2;
			prevHSync = 1'b1;
			edgeSeen = 1'b0;
			aaSpeed = '0;
			aaDiv = '0;
			aaModel = '0;
			busyLeft = 0;
			rdDue = 1'b0;
			rdCheck = 1'b0;
		end else begin
			lineCycle = lineCycle + 1;
			if (hSync && !prevHSync) begin
				if (edgeSeen && lineCycle != linePeriod) begin
					flagMismatch("hSync period", 16'(linePeriod), 16'(lineCycle));
				end
				raster = nextLine(raster);
				lineCycle = 0;
				edgeSeen = 1'b1;
				// Wrap to the first line starts a frame
				if (raster == rasterFirst) begin
					if (aaDiv == 8'd0) begin
						aaModel = aaModel + 3'd1;
						aaDiv = aaSpeed;
					end else begin
						aaDiv = aaDiv - 8'd1;
					end
				end
				if (aaCount != aaModel) begin
					flagMismatch("aaCount", 16'(aaModel), 16'(aaCount));
				end
			end
			if (!hSync && prevHSync && edgeSeen && lineCycle != hSyncHigh) begin
				flagMismatch("hSync high time", 16'(hSyncHigh), 16'(lineCycle));
			end
			prevHSync = hSync;
			// Blank trails the raster by one clock
			if (vBlank != (raster < 9'(vBlankTopEnd) || raster >= 9'(vBlankBottomStart))) begin
				flagMismatch("vBlank", 16'(!vBlank), 16'(vBlank));
			end
			// Raster steps one cycle before the hSync edge
			curRaster = (lineCycle == linePeriod - 1) ? nextLine(raster) : raster;

			if (cpuReqReady != (busyLeft == 0 && !rdDue)) begin
				flagMismatch("cpuReqReady", 16'(busyLeft == 0 && !rdDue), 16'(cpuReqReady));
			end
			if (busyLeft > 0) begin
				busyLeft--;
			end
			if (cpuRdValid && !rdDue) begin
				flagFailure("read response without a request");
			end else if (!cpuRdValid && rdDue) begin
				flagFailure("no read response one cycle after the read");
			end else if (rdDue && rdCheck && cpuRdData != rdExpect) begin
				flagMismatch("cpuRdData", rdExpect, cpuRdData);
			end
			rdDue = 1'b0;

			if (cpuReqValid && cpuReqReady && !cpuWrite) begin
				rdDue = 1'b1;
				rdCheck = 1'b1;
				if (cpuAddr == regLspcMode) begin
					rdExpect = {curRaster, 3'b000, videoModePal, aaCount};
				end else begin
					rdExpect = latch;
					rdCheck = latchKnown;
				end
			end else if (cpuReqValid && cpuReqReady) begin
				case (cpuAddr)
					regVramAddr: begin
						addr = cpuWrData;
						busyLeft = 2;
					end
					regVramRw: begin
						if (addr[vramHighBit]) begin
							highMem[addr[10:0]] = cpuWrData;
							highKnown[addr[10:0]] = 1'b1;
						end else begin
							lowMem[addr[14:0]] = cpuWrData;
							lowKnown[addr[14:0]] = 1'b1;
						end
						addr = addr + modulo;
						busyLeft = 2;
					end
					regVramMod: modulo = cpuWrData;
					default: aaSpeed = cpuWrData[15:8];
				endcase
				// Prefetch from the updated address
				latch = memRead(addr);
				latchKnown = memKnown(addr);
			end
		end
	end

endmodule

`default_nettype wire

// File: lspcTop.sv
// Video controller top level
// Video timing, auto-animation, VRAM access and CPU registers

`default_nettype none

module lspcTop #(
	parameter logic videoModePal = 1'b0
) (
	input wire clk24M,
	input wire reset,
	input wire cpuReqValid,
	output logic cpuReqReady,
	input wire cpuWrite,
	input wire lspcRegPkg::regAddrT cpuAddr,
	input wire lspcRegPkg::cpuWordT cpuWrData,
	output logic cpuRdValid,
	output lspcRegPkg::cpuWordT cpuRdData,
	output logic hSync,
	output logic vBlank,
	output logic [2:0] aaCount
);

	import lspcRegPkg::*;
	import lspcVideoPkg::*;

	// Video timing
	logic frameEnd;
	logic [rasterBits-1:0] rasterCount;

	// Register side to VRAM side
	logic loadAddr;
	logic writeData;
	logic busy;
	cpuWordT newAddr;
	cpuWordT dataWord;
	cpuWordT modulo;
	cpuWordT readLatch;

	logic [7:0] aaSpeed;

	// Pixel enable already folded into frameEnd
	videoSync #(
		.videoModePal(videoModePal)
	) videoSync_inst (
		.clk24M(clk24M),
		.reset(reset),
		.pixelEn(),
		.rasterCount(rasterCount),
		.frameEnd(frameEnd),
		.hSync(hSync),
		.vBlank(vBlank)
	);

	autoAnimTimer autoAnimTimer_inst (
		.clk24M(clk24M),
		.reset(reset),
		.frameEnd(frameEnd),
		.aaSpeed(aaSpeed),
		.aaCount(aaCount)
	);

	vramAccess vramAccess_inst (
		.clk24M(clk24M),
		.reset(reset),
		.loadAddr(loadAddr),
		.newAddr(newAddr),
		.writeData(writeData),
		.dataWord(dataWord),
		.modulo(modulo),
		.busy(busy),
		.readLatch(readLatch)
	);

	lspcRegs #(
		.videoModePal(videoModePal)
	) lspcRegs_inst (
		.clk24M(clk24M),
		.reset(reset),
		.cpuReqValid(cpuReqValid),
		.cpuReqReady(cpuReqReady),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuRdValid(cpuRdValid),
		.cpuRdData(cpuRdData),
		.busy(busy),
		.readLatch(readLatch),
		.rasterCount(rasterCount),
		.aaCount(aaCount),
		.loadAddr(loadAddr),
		.newAddr(newAddr),
		.writeData(writeData),
		.dataWord(dataWord),
		.modulo(modulo),
		.aaSpeed(aaSpeed)
	);

endmodule

`default_nettype wire

// File: lspcRegs.sv
// CPU request and read response handshake
// Modulo and mode registers
// VRAM address and data write strobes
// Read data multiplexer with mode word read view

`default_nettype none

module lspcRegs #(
	parameter logic videoModePal = 1'b0
) (
	input wire clk24M,
	input wire reset,
	input wire cpuReqValid,
	output logic cpuReqReady,
	input wire cpuWrite,
	input wire lspcRegPkg::regAddrT cpuAddr,
	input wire lspcRegPkg::cpuWordT cpuWrData,
	output logic cpuRdValid,
	output lspcRegPkg::cpuWordT cpuRdData,
	input wire busy,
	input wire lspcRegPkg::cpuWordT readLatch,
	input wire [lspcVideoPkg::rasterBits-1:0] rasterCount,
	input wire [2:0] aaCount,
	output logic loadAddr,
	output lspcRegPkg::cpuWordT newAddr,
	output logic writeData,
	output lspcRegPkg::cpuWordT dataWord,
	output lspcRegPkg::cpuWordT modulo,
	output logic [7:0] aaSpeed
);

	import lspcRegPkg::*;

	logic reqAccept;
	logic wrAccept;
	logic rdAccept;

	// Same bits, two decodes
	lspcModeWordT modeWrite;
	lspcModeWordT modeRead;

	cpuWordT rdMux;

	// Stall during VRAM update and the read response cycle
	assign cpuReqReady = !busy && !cpuRdValid;

	assign reqAccept = cpuReqValid && cpuReqReady;
	assign wrAccept = reqAccept && cpuWrite;
	assign rdAccept = reqAccept && !cpuWrite;

	// Strobes to the VRAM unit
	assign loadAddr = wrAccept && (cpuAddr == regVramAddr);
	assign newAddr = cpuWrData;
	assign writeData = wrAccept && (cpuAddr == regVramRw);
	assign dataWord = cpuWrData;

	assign modeWrite = cpuWrData;

	// Status word seen by the CPU
	always_comb begin
		modeRead.rd.rasterLine = rasterCount;
		modeRead.rd.zero = '0;
		modeRead.rd.videoModePal = videoModePal;
		modeRead.rd.aaCount = aaCount;
	end

	// VRAM registers all read back the prefetch latch
	always_comb begin
		case (cpuAddr)
			regLspcMode: rdMux = modeRead;
			default: rdMux = readLatch;
		endcase
	end

	// Modulo and mode registers
	always_ff @(posedge clk24M) begin
		if (reset) begin
			modulo <= '0;
			aaSpeed <= '0;
		end else if (wrAccept) begin
			if (cpuAddr == regVramMod) begin
				modulo <= cpuWrData;
			end
			if (cpuAddr == regLspcMode) begin
				aaSpeed <= modeWrite.wr.aaSpeed;
			end
		end
	end

	// Response one cycle after the read
	always_ff @(posedge clk24M) begin
		if (reset) begin
			cpuRdValid <= 1'b0;
		end else begin
			cpuRdValid <= rdAccept;
		end
	end

	// Response data
	always_ff @(posedge clk24M) begin
		if (rdAccept) begin
			cpuRdData <= rdMux;
		end
	end

endmodule

`default_nettype wire

// File: vramAccess.sv
// Slow and fast VRAM arrays
// CPU VRAM address register with modulo increment
// Read prefetch into the CPU read latch
// Busy flag covering the two update cycles

`default_nettype none

module vramAccess (
	input wire clk24M,
	input wire reset,
	input wire loadAddr,
	input wire lspcRegPkg::cpuWordT newAddr,
	input wire writeData,
	input wire lspcRegPkg::cpuWordT dataWord,
	input wire lspcRegPkg::cpuWordT modulo,
	output logic busy,
	output lspcRegPkg::cpuWordT readLatch
);

	import lspcRegPkg::*;

	localparam int lowBits = $clog2(vramLowWords);
	localparam int highBits = $clog2(vramHighWords);

	cpuWordT vramLow [vramLowWords];
	cpuWordT vramHigh [vramHighWords];

	// Current CPU VRAM address
	cpuWordT vramAddr;

	logic [lowBits-1:0] lowIdx;
	logic [highBits-1:0] highIdx;
	logic highZone;

	// Prefetch sequence, array read then latch load
	logic fetchRead;
	logic fetchLatch;

	// Array outputs and zone of the fetched address
	cpuWordT lowQ;
	cpuWordT highQ;
	logic highQSel;

	assign lowIdx = vramAddr[lowBits-1:0];
	// Upper bits ignored, fast zone mirrors
	assign highIdx = vramAddr[highBits-1:0];
	assign highZone = vramAddr[vramHighBit];

	assign busy = fetchRead || fetchLatch;

	// Address register and prefetch sequencing
	always_ff @(posedge clk24M) begin
		if (reset) begin
			vramAddr <= '0;
			fetchRead <= 1'b0;
			fetchLatch <= 1'b0;
			readLatch <= '0;
		end else begin
			fetchRead <= loadAddr || writeData;
			fetchLatch <= fetchRead;
			if (loadAddr) begin
				vramAddr <= newAddr;
			end else if (writeData) begin
				// Signed step, 16-bit wrap
				vramAddr <= vramAddr + modulo;
			end
			if (fetchLatch) begin
				readLatch <= highQSel ? highQ : lowQ;
			end
		end
	end

	// Zone-steered write at the old address
	always_ff @(posedge clk24M) begin
		if (writeData) begin
			if (highZone) begin
				vramHigh[highIdx] <= dataWord;
			end else begin
				vramLow[lowIdx] <= dataWord;
			end
		end
	end

	// Synchronous read of the updated address
	always_ff @(posedge clk24M) begin
		if (fetchRead) begin
			lowQ <= vramLow[lowIdx];
			highQ <= vramHigh[highIdx];
			highQSel <= highZone;
		end
	end

endmodule

`default_nettype wire

// File: autoAnimTimer.sv
// Auto-animation frame divider
// 3-bit tile counter stepped every aaSpeed+1 frames

`default_nettype none

module autoAnimTimer (
	input wire clk24M,
	input wire reset,
	input wire frameEnd,
	input wire [7:0] aaSpeed,
	output logic [2:0] aaCount
);

	// Frames left before the next step
	logic [7:0] frameDiv;

	// Updates on the frameEnd edge itself
	always_ff @(posedge clk24M) begin
		if (reset) begin
			frameDiv <= '0;
			aaCount <= '0;
		end else if (frameEnd) begin
			if (frameDiv == 8'd0) begin
				// Step tile, wraps after 8
				aaCount <= aaCount + 3'd1;
				frameDiv <= aaSpeed;
			end else begin
				frameDiv <= frameDiv - 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: videoSync.sv
// Pixel clock enable from the 24 MHz clock
// Pixel and raster counters
// Registered hSync and vBlank decodes
// Frame end pulse for the auto-animation timer

`default_nettype none

module videoSync #(
	parameter logic videoModePal = 1'b0
) (
	input wire clk24M,
	input wire reset,
	output logic pixelEn,
	output logic [lspcVideoPkg::rasterBits-1:0] rasterCount,
	output logic frameEnd,
	output logic hSync,
	output logic vBlank
);

	import lspcVideoPkg::*;

	localparam int divBits = $clog2(clocksPerPixel);

	// Line loaded after the last raster line
	localparam logic [rasterBits-1:0] rasterFirst =
		videoModePal ? rasterBits'(rasterFirstPal) : rasterBits'(rasterFirstNtsc);

	logic [divBits-1:0] clkDiv;
	logic [pixelBits-1:0] pixelCount;
	logic lineEnd;

	// One enable per 4 clocks
	assign pixelEn = (clkDiv == divBits'(clocksPerPixel - 1));

	// Last pixel of the line, on its enable
	assign lineEnd = pixelEn && (pixelCount == pixelBits'(pixelsPerLine - 1));

	// Last pixel of line 511
	assign frameEnd = lineEnd && (rasterCount == rasterBits'(rasterLast));

	// Clock divider
	always_ff @(posedge clk24M) begin
		if (reset) begin
			clkDiv <= '0;
		end else begin
			clkDiv <= clkDiv + divBits'(1);
		end
	end

	// Pixel and raster counters
	always_ff @(posedge clk24M) begin
		if (reset) begin
			pixelCount <= '0;
			rasterCount <= rasterFirst;
		end else if (pixelEn) begin
			if (lineEnd) begin
				pixelCount <= '0;
				// Raster wraps to the mode's first line
				if (rasterCount == rasterBits'(rasterLast)) begin
					rasterCount <= rasterFirst;
				end else begin
					rasterCount <= rasterCount + rasterBits'(1);
				end
			end else begin
				pixelCount <= pixelCount + pixelBits'(1);
			end
		end
	end

	// Sync and blank, one clock behind the counters
	always_ff @(posedge clk24M) begin
		if (reset) begin
			hSync <= 1'b1;
			vBlank <= 1'b1;
		end else begin
			hSync <= (pixelCount < pixelBits'(hSyncPixels));
			// Top and bottom borders
			vBlank <= (rasterCount < rasterBits'(vBlankTopEnd)) ||
				(rasterCount >= rasterBits'(vBlankBottomStart));
		end
	end

endmodule

`default_nettype wire

// File: lspcVideoPkg.sv
// Video timing constants
// Line length, pixel clock ratio and counter widths
// Raster start lines for both video modes
// Sync and blanking decode points

`default_nettype none

package lspcVideoPkg;

	// Horizontal timing
	localparam int pixelsPerLine = 384;
	localparam int clocksPerPixel = 4;
	localparam int pixelBits = 9;

	// Vertical timing
	localparam int rasterBits = 9;
	localparam int rasterLast = 511;

	// First line after wrap, 264 lines per frame
	localparam int rasterFirstNtsc = 248;
	// First line after wrap, 312 lines per frame
	localparam int rasterFirstPal = 200;

	// hSync active for the first pixels of each line
	localparam int hSyncPixels = 28;

	// Blanked below this line
	localparam int vBlankTopEnd = 272;
	// And again from this line up
	localparam int vBlankBottomStart = 496;

endpackage

`default_nettype wire

// File: lspcRegPkg.sv
// CPU view of the video controller registers
// Register word addresses and the CPU data word
// Mode word union with separate write and read layouts
// VRAM zone sizes and zone select bit

`default_nettype none

package lspcRegPkg;

	// Register word address, CPU address bits 2:1
	typedef logic [1:0] regAddrT;

	localparam regAddrT regVramAddr = 2'd0;
	localparam regAddrT regVramRw = 2'd1;
	localparam regAddrT regVramMod = 2'd2;
	localparam regAddrT regLspcMode = 2'd3;

	// 16-bit CPU data bus word
	typedef logic [15:0] cpuWordT;

	// Mode register, layout depends on direction
	typedef union packed {
		// Written by the CPU
		struct packed {
			logic [7:0] aaSpeed;
			// Timer and AA disable bits, not implemented
			logic [7:0] ignored;
		} wr;
		// Read back by the CPU
		struct packed {
			logic [8:0] rasterLine;
			logic [2:0] zero;
			logic       videoModePal;
			logic [2:0] aaCount;
		} rd;
	} lspcModeWordT;

	// Address bit 15 picks the fast (high) zone
	localparam int vramHighBit = 15;

	// Slow VRAM, 32K words
	localparam int vramLowWords = 32768;

	// Fast VRAM, 2K words
	// Only 11 address bits decoded so the zone repeats
	localparam int vramHighWords = 2048;

endpackage

`default_nettype wire
